// ==== build.f ====
mm_pkg.sv
stream_fifo.sv
mm_controller.sv
operand_reader.sv
outer_product_mac.sv
result_writer.sv
mm_top.sv
tb_clock_gen.sv
mm_properties.sv
mm_tb.sv

// ==== mm_controller.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-multiply controller
// Takes one instruction at a time, latches the job, starts
// the readers, MAC and writer, and pulses done at the end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mm_controller import mm_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  instr_valid_i,   // Host has an instruction
  input  addr_t a_addr_i,
  input  addr_t b_addr_i,
  input  addr_t c_addr_i,
  input  len_t  len_i,           // Inner length, 1..MAX_MATRIX_LENGTH
  output logic  instr_ready_o,   // High only while idle
  output logic  start_o,         // One-cycle kick to all stages
  output addr_t a_base_o,
  output addr_t b_base_o,
  output addr_t c_base_o,
  output len_t  len_o,
  input  logic  job_done_i,      // Last C row accepted by memory
  output logic  done_o
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e state_q;
  logic   accept;

  assign instr_ready_o = (state_q == ST_IDLE);
  assign accept        = instr_valid_i && instr_ready_o; // Instruction handshake

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      start_o <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      start_o <= accept;         // Start lands the cycle after accept
      done_o  <= 1'b0;
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_BUSY;
        ST_BUSY: begin
          if (job_done_i) begin
            state_q <= ST_IDLE;  // Ready rises together with done
            done_o  <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Job fields, held for the whole busy period
  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_base_o <= a_addr_i;
      b_base_o <= b_addr_i;
      c_base_o <= c_addr_i;
      len_o    <= len_i;
    end
  end

endmodule

// ==== mm_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-multiply accelerator shared definitions
// Operand, accumulator, address and length widths and the
// vector types carried between the pipeline stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mm_pkg;

  localparam int DATA_WIDTH = 8;                       // 8-bit unsigned operands
  localparam int N = 4;                                // Tile edge, operands per word
  localparam int MULTIPLY_DATA_WIDTH = 2 * DATA_WIDTH; // Full product width
  localparam int ACCUM_DATA_WIDTH = 16;                // Headroom for the running sum
  localparam int ACC_WIDTH = MULTIPLY_DATA_WIDTH + ACCUM_DATA_WIDTH;

  localparam int ADDR_WIDTH = 16;                      // Counts N-wide memory words
  localparam int MAX_MATRIX_LENGTH = 4096;             // Longest inner dimension
  localparam int LEN_WIDTH = $clog2(MAX_MATRIX_LENGTH + 1); // Holds 0..MAX_MATRIX_LENGTH

  localparam int FIFO_DEPTH = 4;                       // Entries per stage FIFO

  typedef logic [DATA_WIDTH-1:0] data_t;               // One operand
  typedef logic [ACC_WIDTH-1:0]  acc_t;                // One accumulator
  typedef logic [ADDR_WIDTH-1:0] addr_t;               // Word address
  typedef logic [LEN_WIDTH-1:0]  len_t;                // Inner length L

  // A column slice of A or a row slice of B, one read word
  typedef data_t [N-1:0] operand_vec_t;

  // One row of the C tile, one write word
  typedef acc_t [N-1:0] result_row_t;

endpackage

// ==== mm_properties.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-multiply port properties
// Handshake stability on the read and write ports and a
// single-cycle done pulse, bound onto the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mm_properties import mm_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        a_rd_req_i,   // A read port
  input addr_t       a_rd_addr_i,
  input logic        a_rd_valid_i,
  input logic        b_rd_req_i,   // B read port
  input addr_t       b_rd_addr_i,
  input logic        b_rd_valid_i,
  input logic        wr_valid_i,   // C write port
  input addr_t       wr_addr_i,
  input result_row_t wr_data_i,
  input logic        wr_ready_i,
  input logic        done_i
);

  // Stalled write keeps valid, address and data
  wr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_addr_i) && $stable(wr_data_i))
    else $error("C write changed while stalled");

  a_addr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    a_rd_req_i && !a_rd_valid_i |=> a_rd_req_i && $stable(a_rd_addr_i))
    else $error("A read request dropped or address moved before data");

  b_addr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_rd_req_i && !b_rd_valid_i |=> b_rd_req_i && $stable(b_rd_addr_i))
    else $error("B read request dropped or address moved before data");

  done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
    else $error("done high for two cycles");

endmodule

// ==== mm_tb.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-multiply testbench
// Random jobs through A/B memory models with random read
// latency and a back-pressured C port, each row checked
// against a reference model of the tile
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mm_tb import mm_pkg::*; ();

  localparam int NUM_JOBS = 20;                    // 19 random jobs, then L=64 stress
  localparam int TIMEOUT_CYCLES = NUM_JOBS * 1000; // L=64 at ~5 cycles per slice plus stalls

  logic         clk_i, rst_n_i;
  logic         instr_valid_i, instr_ready_o, done_o;
  addr_t        a_addr_i, b_addr_i, c_addr_i;
  len_t         len_i;
  logic         a_rd_req_o, a_rd_valid_i, b_rd_req_o, b_rd_valid_i;
  addr_t        a_rd_addr_o, b_rd_addr_o, wr_addr_o;
  operand_vec_t a_rd_data_i, b_rd_data_i;
  logic         wr_valid_o, wr_ready_i;
  result_row_t  wr_data_o;

  operand_vec_t [255:0] a_mem;                     // Indexed by low 8 address bits
  operand_vec_t [255:0] b_mem;
  result_row_t  exp_c [N];                         // Expected tile, row i is C(i,*)
  integer       seed;
  int           cycles, job_id, wr_count;
  int           a_wait, b_wait;                    // Read latency countdown, -1 when idle
  int           a_k, b_k;                          // Reads served this job
  logic         busy, done_due, stress;

  tb_clock_gen u_clock (.clk_o(clk_i), .rst_n_o(rst_n_i));

  mm_top dut0 (.*);

  bind mm_top mm_properties u_properties (.clk_i(clk_i), .rst_n_i(rst_n_i),
    .a_rd_req_i(a_rd_req_o), .a_rd_addr_i(a_rd_addr_o), .a_rd_valid_i(a_rd_valid_i),
    .b_rd_req_i(b_rd_req_o), .b_rd_addr_i(b_rd_addr_o), .b_rd_valid_i(b_rd_valid_i),
    .wr_valid_i(wr_valid_o), .wr_addr_i(wr_addr_o), .wr_data_i(wr_data_o),
    .wr_ready_i(wr_ready_i), .done_i(done_o));

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_len(input string name, input len_t exp, input len_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_row(input string name, input result_row_t exp, input result_row_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // C(i,j) is the sum over k of A word k operand i times B word k operand j
  task automatic reference_product();
    acc_t  sum;
    addr_t a_idx, b_idx;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        sum = '0;
        for (int k = 0; k < int'(len_i); k++) begin
          a_idx = a_addr_i + addr_t'(k);
          b_idx = b_addr_i + addr_t'(k);
          sum   = sum + acc_t'(a_mem[a_idx[7:0]][i]) * acc_t'(b_mem[b_idx[7:0]][j]);
        end
        exp_c[i][j] = sum;
      end
    end
  endtask

  // One read port, answers a held request after 0 to 3 cycles
  task automatic serve_read(input string name, input logic req, input addr_t addr,
                            input addr_t base, input operand_vec_t word,
                            inout int wait_cnt, inout int k,
                            output logic valid, output operand_vec_t data);
    valid = 1'b0;
    data  = word;
    if (req) begin
      if (wait_cnt < 0) wait_cnt = $random(seed) & 3;  // New request, pick latency
      if (wait_cnt == 0) begin
        check_addr($sformatf("job %0d %s read %0d", job_id, name, k), base + addr_t'(k), addr);
        valid    = 1'b1;
        k        = k + 1;
        wait_cnt = -1;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  endtask

  // Memory models and monitors for one clock, run at the falling edge
  task automatic service_cycle();
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Run hung: job %0d saw no done pulse within %0d cycles", job_id, TIMEOUT_CYCLES);
      abort_run();
    end
    check_flag($sformatf("job %0d done pulse", job_id), done_due, done_o);
    done_due = 1'b0;
    if (done_o) busy = 1'b0;                        // Ready comes back with done
    check_flag($sformatf("job %0d instr_ready", job_id), !busy, instr_ready_o);
    serve_read("A", a_rd_req_o, a_rd_addr_o, a_addr_i, a_mem[a_rd_addr_o[7:0]], a_wait, a_k,
               a_rd_valid_i, a_rd_data_i);
    serve_read("B", b_rd_req_o, b_rd_addr_o, b_addr_i, b_mem[b_rd_addr_o[7:0]], b_wait, b_k,
               b_rd_valid_i, b_rd_data_i);
    if (stress) wr_ready_i = ($random(seed) & 31) == 0;  // Long low stretches
    else        wr_ready_i = ($random(seed) & 1) != 0;
    if (wr_valid_o && wr_ready_i) begin               // Write completes at next edge
      check_flag($sformatf("job %0d write inside tile", job_id), 1'b1, wr_count < N);
      check_addr($sformatf("job %0d write %0d address", job_id, wr_count),
                 c_addr_i + addr_t'(wr_count), wr_addr_o);
      check_row($sformatf("job %0d row %0d", job_id, wr_count), exp_c[wr_count], wr_data_o);
      wr_count++;
      done_due = (wr_count == N);                    // Done due one cycle later
    end
  endtask

  task automatic run_job(input len_t len, input logic heavy);
    addr_t a_idx, b_idx;
    stress   = heavy;
    len_i    = len;
    a_addr_i = addr_t'($random(seed));
    b_addr_i = addr_t'($random(seed));
    c_addr_i = addr_t'($random(seed));
    for (int k = 0; k < int'(len); k++) begin
      a_idx = a_addr_i + addr_t'(k);
      b_idx = b_addr_i + addr_t'(k);
      a_mem[a_idx[7:0]] = heavy ? '1 : operand_vec_t'($random(seed));
      b_mem[b_idx[7:0]] = heavy ? '1 : operand_vec_t'($random(seed));
    end
    if (heavy) begin
      for (int i = 0; i < N; i++) exp_c[i] = {N{acc_t'(64 * 255 * 255)}};  // All 255, L=64
    end else begin
      reference_product();
    end
    a_k      = 0;
    b_k      = 0;
    a_wait   = -1;
    b_wait   = -1;
    wr_count = 0;
    instr_valid_i = 1'b1;                            // Ready is high, taken at next edge
    busy          = 1'b1;
    @(negedge clk_i);
    service_cycle();
    instr_valid_i = 1'b0;
    while (busy) begin
      @(negedge clk_i);
      service_cycle();
    end
    check_len($sformatf("job %0d A reads", job_id), len, len_t'(a_k));
    check_len($sformatf("job %0d B reads", job_id), len, len_t'(b_k));
    job_id++;
  endtask

  initial begin
    seed          = 32'hcfc3_e28c;
    instr_valid_i = 1'b0;
    a_addr_i      = '0;
    b_addr_i      = '0;
    c_addr_i      = '0;
    len_i         = len_t'(1);
    a_rd_valid_i  = 1'b0;
    a_rd_data_i   = '0;
    b_rd_valid_i  = 1'b0;
    b_rd_data_i   = '0;
    wr_ready_i    = 1'b0;
    cycles        = 0;
    job_id        = 0;
    wr_count      = 0;
    a_wait        = -1;
    b_wait        = -1;
    a_k           = 0;
    b_k           = 0;
    busy          = 1'b0;
    done_due      = 1'b0;
    stress        = 1'b0;
    @(posedge rst_n_i);
    @(negedge clk_i);
    check_flag("idle instr_ready", 1'b1, instr_ready_o);  // Idle state after reset
    check_flag("idle done", 1'b0, done_o);
    check_flag("idle A request", 1'b0, a_rd_req_o);
    check_flag("idle B request", 1'b0, b_rd_req_o);
    check_flag("idle write valid", 1'b0, wr_valid_o);
    for (int j = 0; j < NUM_JOBS - 1; j++) begin
      run_job(len_t'(1 + ($random(seed) & 7)), 1'b0);    // L from 1 to 8
    end
    run_job(len_t'(64), 1'b1);
    $display("No errors");
    $finish;
  end

endmodule

// ==== mm_top.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix-multiply compute path
// Controller, A and B readers with FIFOs, outer-product MAC,
// result FIFO and C writer chained into one pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mm_top import mm_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         instr_valid_i,
  input  addr_t        a_addr_i,
  input  addr_t        b_addr_i,
  input  addr_t        c_addr_i,
  input  len_t         len_i,
  output logic         instr_ready_o,
  output logic         done_o,
  output logic         a_rd_req_o,      // A read port
  output addr_t        a_rd_addr_o,
  input  logic         a_rd_valid_i,
  input  operand_vec_t a_rd_data_i,
  output logic         b_rd_req_o,      // B read port
  output addr_t        b_rd_addr_o,
  input  logic         b_rd_valid_i,
  input  operand_vec_t b_rd_data_i,
  output logic         wr_valid_o,      // C write port
  output addr_t        wr_addr_o,
  output result_row_t  wr_data_o,
  input  logic         wr_ready_i
);

  logic         start;
  addr_t        a_base, b_base, c_base;
  len_t         len;
  logic         job_done;
  logic         a_push, a_full, a_pop, a_empty;
  operand_vec_t a_push_data, a_pop_data;
  logic         b_push, b_full, b_pop, b_empty;
  operand_vec_t b_push_data, b_pop_data;
  logic         c_push, c_full, c_pop, c_empty;
  result_row_t  c_push_data, c_pop_data;

  mm_controller u_controller (.clk_i, .rst_n_i, .instr_valid_i, .a_addr_i, .b_addr_i,
    .c_addr_i, .len_i, .instr_ready_o, .start_o(start), .a_base_o(a_base), .b_base_o(b_base),
    .c_base_o(c_base), .len_o(len), .job_done_i(job_done), .done_o);

  operand_reader u_a_reader (.clk_i, .rst_n_i, .start_i(start), .base_i(a_base), .len_i(len),
    .rd_req_o(a_rd_req_o), .rd_addr_o(a_rd_addr_o), .rd_valid_i(a_rd_valid_i),
    .rd_data_i(a_rd_data_i), .push_o(a_push), .push_data_o(a_push_data), .fifo_full_i(a_full));

  operand_reader u_b_reader (.clk_i, .rst_n_i, .start_i(start), .base_i(b_base), .len_i(len),
    .rd_req_o(b_rd_req_o), .rd_addr_o(b_rd_addr_o), .rd_valid_i(b_rd_valid_i),
    .rd_data_i(b_rd_data_i), .push_o(b_push), .push_data_o(b_push_data), .fifo_full_i(b_full));

  stream_fifo #(.T(operand_vec_t)) u_a_fifo (.clk_i, .rst_n_i, .push_i(a_push),
    .push_data_i(a_push_data), .full_o(a_full), .pop_i(a_pop), .pop_data_o(a_pop_data),
    .empty_o(a_empty));

  stream_fifo #(.T(operand_vec_t)) u_b_fifo (.clk_i, .rst_n_i, .push_i(b_push),
    .push_data_i(b_push_data), .full_o(b_full), .pop_i(b_pop), .pop_data_o(b_pop_data),
    .empty_o(b_empty));

  outer_product_mac u_mac (.clk_i, .rst_n_i, .start_i(start), .len_i(len), .a_empty_i(a_empty),
    .b_empty_i(b_empty), .a_data_i(a_pop_data), .b_data_i(b_pop_data), .a_pop_o(a_pop),
    .b_pop_o(b_pop), .row_push_o(c_push), .row_o(c_push_data), .c_full_i(c_full));

  stream_fifo #(.T(result_row_t)) u_c_fifo (.clk_i, .rst_n_i, .push_i(c_push),
    .push_data_i(c_push_data), .full_o(c_full), .pop_i(c_pop), .pop_data_o(c_pop_data),
    .empty_o(c_empty));

  result_writer u_writer (.clk_i, .rst_n_i, .start_i(start), .base_i(c_base),
    .c_empty_i(c_empty), .c_data_i(c_pop_data), .c_pop_o(c_pop), .wr_valid_o, .wr_addr_o,
    .wr_data_o, .wr_ready_i, .job_done_o(job_done));

endmodule

// ==== operand_reader.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand reader
// Fetches L consecutive slices of one matrix, one read in
// flight, and forwards each returned word into its FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module operand_reader import mm_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         start_i,      // New job
  input  addr_t        base_i,       // Address of slice 0
  input  len_t         len_i,        // Slices to fetch
  output logic         rd_req_o,     // Level, held until data returns
  output addr_t        rd_addr_o,
  input  logic         rd_valid_i,   // Read data pulse
  input  operand_vec_t rd_data_i,
  output logic         push_o,       // Into operand FIFO
  output operand_vec_t push_data_o,
  input  logic         fifo_full_i
);

  addr_t base_q;
  len_t  len_q;
  len_t  k_q;                        // Slices returned so far
  logic  req_q;
  logic  taken;
  logic  more;

  assign taken = req_q && rd_valid_i;         // Word accepted this cycle
  assign more  = (k_q != len_q);              // Slices still to fetch

  assign rd_req_o    = req_q;
  assign rd_addr_o   = base_q + addr_t'(k_q); // Stable while req is up
  assign push_o      = taken;
  assign push_data_o = rd_data_i;             // Straight through, FIFO registers it

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      len_q <= '0;
      k_q   <= '0;
      req_q <= 1'b0;
    end else if (start_i) begin
      len_q <= len_i;
      k_q   <= '0;
      req_q <= !fifo_full_i;         // First request right after start
    end else if (taken) begin
      k_q   <= k_q + 1'b1;
      req_q <= 1'b0;                 // Drop, FIFO level settles next cycle
    end else if (!req_q && more && !fifo_full_i) begin
      req_q <= 1'b1;                 // Room left, ask for next slice
    end
  end

  // Base address of the current job
  always_ff @(posedge clk_i) begin
    if (start_i) base_q <= base_i;
  end

endmodule

// ==== outer_product_mac.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Outer-product MAC
// Sums L outer products of A and B slices into the NxN tile
// through a product stage, then drains the tile row by row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module outer_product_mac import mm_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         start_i,        // Clear tile, load L
  input  len_t         len_i,
  input  logic         a_empty_i,
  input  logic         b_empty_i,
  input  operand_vec_t a_data_i,       // Column slice of A
  input  operand_vec_t b_data_i,       // Row slice of B
  output logic         a_pop_o,
  output logic         b_pop_o,
  output logic         row_push_o,     // Into result FIFO
  output result_row_t  row_o,
  input  logic         c_full_i
);

  logic [MULTIPLY_DATA_WIDTH-1:0] prod_q [N][N]; // a[i]*b[j]
  result_row_t                    acc_q [N];     // Tile, row i holds C(i,*)
  logic                           prod_valid_q;
  len_t                           len_q;
  len_t                           taken_q;       // Pairs popped
  len_t                           summed_q;      // Pairs accumulated
  logic                           drain_q;
  logic [$clog2(N)-1:0]           row_q;         // Next row to push
  logic                           pop;

  assign pop        = (taken_q != len_q) && !a_empty_i && !b_empty_i;
  assign a_pop_o    = pop;                       // Both FIFOs move together
  assign b_pop_o    = pop;
  assign row_push_o = drain_q && !c_full_i;
  assign row_o      = acc_q[row_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prod_valid_q <= 1'b0;
      len_q        <= '0;
      taken_q      <= '0;
      summed_q     <= '0;
      drain_q      <= 1'b0;
      row_q        <= '0;
    end else if (start_i) begin
      prod_valid_q <= 1'b0;
      len_q        <= len_i;
      taken_q      <= '0;
      summed_q     <= '0;
      row_q        <= '0;
    end else begin
      prod_valid_q <= pop;
      if (pop) taken_q <= taken_q + 1'b1;
      if (prod_valid_q) begin
        summed_q <= summed_q + 1'b1;
        if (summed_q == len_q - 1'b1) drain_q <= 1'b1; // Lth pair lands now
      end
      if (row_push_o) begin
        row_q <= (row_q == N - 1) ? '0 : row_q + 1'b1;
        if (row_q == N - 1) drain_q <= 1'b0;           // Tile fully sent
      end
    end
  end

  // Product stage and accumulators
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        prod_q[i][j] <= a_data_i[i] * b_data_i[j];
        if (start_i) acc_q[i][j] <= '0;
        else if (prod_valid_q) acc_q[i][j] <= acc_q[i][j] + acc_t'(prod_q[i][j]);
      end
    end
  end

endmodule

// ==== result_writer.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result writer
// Moves the N rows of the C tile from the result FIFO to
// memory and flags the job done on the last accepted row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module result_writer import mm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        start_i,       // New job, load C base
  input  addr_t       base_i,
  input  logic        c_empty_i,
  input  result_row_t c_data_i,      // Head of result FIFO
  output logic        c_pop_o,
  output logic        wr_valid_o,
  output addr_t       wr_addr_o,
  output result_row_t wr_data_o,
  input  logic        wr_ready_i,
  output logic        job_done_o     // Same cycle as the last write handshake
);

  addr_t                base_q;
  result_row_t          data_q;
  logic                 valid_q;
  logic [$clog2(N)-1:0] row_q;       // Row being written
  logic                 wr_done;

  assign c_pop_o    = !valid_q && !c_empty_i;    // Fetch only when idle
  assign wr_done    = valid_q && wr_ready_i;
  assign wr_valid_o = valid_q;
  assign wr_addr_o  = base_q + addr_t'(row_q);   // Row r goes to base+r
  assign wr_data_o  = data_q;
  assign job_done_o = wr_done && (row_q == N - 1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      row_q   <= '0;
    end else if (start_i) begin
      valid_q <= 1'b0;
      row_q   <= '0;
    end else if (c_pop_o) begin
      valid_q <= 1'b1;
    end else if (wr_done) begin
      valid_q <= 1'b0;
      row_q   <= (row_q == N - 1) ? '0 : row_q + 1'b1;
    end
  end

  // Row payload and C base
  always_ff @(posedge clk_i) begin
    if (start_i) base_q <= base_i;
    if (c_pop_o) data_q <= c_data_i;  // Held until memory takes it
  end

endmodule

// ==== stream_fifo.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream FIFO
// Small synchronous circular buffer, payload type set per
// instance, head entry visible at the output without a pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module stream_fifo import mm_pkg::*; #(
  parameter type T = operand_vec_t                 // Payload carried by the FIFO
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,                             // Write request from producer
  input  T     push_data_i,
  output logic full_o,
  input  logic pop_i,                              // Read request from consumer
  output T     pop_data_o,                         // Head of queue
  output logic empty_o
);

  T                               mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr_q;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count_q;        // Entries held
  logic                           do_push;
  logic                           do_pop;

  assign full_o     = (count_q == FIFO_DEPTH);
  assign empty_o    = (count_q == 0);
  assign do_push    = push_i && !full_o;           // Push into a full FIFO is dropped
  assign do_pop     = pop_i && !empty_o;
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)      count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// 10 ns clock, reset held low for the first 10 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;     // 100 MHz
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);  // Ten full cycles in reset
    @(negedge clk_o);
    rst_n_o = 1'b1;                // Released mid-cycle
  end

endmodule
